// File: hdl/ccm_pkg.sv
// Sizes fixed for a 4 KB DCCM and a 4 KB ICCM of four banks each, ECC kept in the top 7 bits
`default_nettype none

package ccm_pkg;

   // ******************************
   // Memory geometry
   // ******************************
   localparam int DCCM_BITS   = 12;  // DCCM byte address
   localparam int ICCM_BITS   = 12;  // ICCM byte address
   localparam int NUM_BANKS   = 4;
   localparam int BANK_ROWS   = 256;

   // ******************************
   // Word layout
   // ******************************
   localparam int DATA_WIDTH  = 32;
   localparam int ECC_WIDTH   = 7;   // Six Hamming bits plus overall parity
   localparam int FDATA_WIDTH = DATA_WIDTH + ECC_WIDTH;

   typedef logic [DCCM_BITS-1:0]         dccm_addr_t;
   typedef logic [ICCM_BITS-3:0]         iccm_addr_t;  // Word address
   typedef logic [FDATA_WIDTH-1:0]       fdata_t;      // {ecc, data}
   typedef logic [DATA_WIDTH-1:0]        data_t;
   typedef logic [$clog2(BANK_ROWS)-1:0] row_t;
   typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
   typedef logic [NUM_BANKS-1:0]         bank_vec_t;

endpackage

`default_nettype wire

// File: hdl/sram_bank.sv
// Single port bank; a write cycle leaves the read register untouched, contents are not reset
`timescale 1ns/1ps
`default_nettype none

module sram_bank import ccm_pkg::*; (
   input  wire         clk,
   input  wire         rst_n,
   input  wire         en,
   input  wire         we,
   input  wire row_t   row,
   input  wire fdata_t wdata,
   output fdata_t      rdata
);

   fdata_t mem [BANK_ROWS];

   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[row] <= wdata;
      end
   end

   // Output register holds until the next read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (en && !we) begin
         rdata <= mem[row];
      end
   end

endmodule

`default_nettype wire

// File: hdl/secded_decode.sv
// Purely combinational; a syndrome that points at a check bit or past bit 38 leaves the data as is
`timescale 1ns/1ps
`default_nettype none

module secded_decode import ccm_pkg::*; (
   input  wire fdata_t codeword,
   output data_t       data,
   output logic        sb_err,
   output logic        db_err
);

   localparam int HAM_TOP = FDATA_WIDTH - 1;  // Highest Hamming position
   localparam int SYN_W   = ECC_WIDTH - 1;

   logic [HAM_TOP:1] ham;         // Codeword in Hamming position order
   logic [SYN_W-1:0] syndrome;
   logic             parity_err;

   // ******************************
   // Scatter into positions
   // ******************************
   always_comb begin
      int d;
      int k;
      d = 0;
      k = 0;
      for (int p = 1; p <= HAM_TOP; p++) begin
         if ((p & (p - 1)) == 0) begin
            ham[p] = codeword[DATA_WIDTH + k];  // Check bit at 2^k
            k++;
         end else begin
            ham[p] = codeword[d];
            d++;
         end
      end
   end

   // Each syndrome bit covers the positions with that address bit set
   always_comb begin
      syndrome = '0;
      for (int p = 1; p <= HAM_TOP; p++) begin
         for (int b = 0; b < SYN_W; b++) begin
            if (((p >> b) & 1) == 1) begin
               syndrome[b] = syndrome[b] ^ ham[p];
            end
         end
      end
   end

   assign parity_err = ^codeword;  // Even over all 39 bits

   // ******************************
   // Correction
   // ******************************
   always_comb begin
      int d;
      d = 0;
      data = codeword[DATA_WIDTH-1:0];
      for (int p = 1; p <= HAM_TOP; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (parity_err && (syndrome == SYN_W'(p))) begin
               data[d] = ~data[d];
            end
            d++;
         end
      end
   end

   assign sb_err = parity_err;
   assign db_err = (syndrome != '0) && !parity_err;  // Two flips cancel the parity

endmodule

`default_nettype wire

// File: hdl/ccm_ctrl.sv
// A write strobe overrides a read in the same cycle; ICCM sizes other than 3'b011 write one word
`timescale 1ns/1ps
`default_nettype none

module ccm_ctrl import ccm_pkg::*; (
   input  wire                  clk,
   input  wire                  rst_n,

   input  wire                  dccm_wren,
   input  wire                  dccm_rden,
   input  wire dccm_addr_t      dccm_wr_addr_lo,
   input  wire dccm_addr_t      dccm_wr_addr_hi,
   input  wire dccm_addr_t      dccm_rd_addr_lo,
   input  wire dccm_addr_t      dccm_rd_addr_hi,

   input  wire                  iccm_wren,
   input  wire                  iccm_rden,
   input  wire iccm_addr_t      iccm_rw_addr,
   input  wire [2:0]            iccm_wr_size,

   output bank_vec_t            dccm_bank_en,
   output bank_vec_t            dccm_bank_we,
   output bank_vec_t            dccm_bank_sel_hi,
   output row_t [NUM_BANKS-1:0] dccm_bank_row,
   output bank_idx_t            dccm_rd_bank_lo_q,
   output bank_idx_t            dccm_rd_bank_hi_q,

   output bank_vec_t            iccm_bank_en,
   output bank_vec_t            iccm_bank_we,
   output bank_vec_t            iccm_bank_sel_hi,
   output row_t [NUM_BANKS-1:0] iccm_bank_row,
   output bank_idx_t            iccm_rd_bank_q
);

   dccm_addr_t dccm_addr_lo;
   dccm_addr_t dccm_addr_hi;
   bank_idx_t  dccm_bank_lo;
   bank_idx_t  dccm_bank_hi;
   logic       dccm_access;
   logic       dccm_rd_go;

   iccm_addr_t iccm_addr_nxt;
   bank_idx_t  iccm_bank_0;
   bank_idx_t  iccm_bank_1;
   logic       iccm_access;
   logic       iccm_second;   // Next word also accessed
   logic       iccm_rd_go;

   // ******************************
   // DCCM decode
   // ******************************
   assign dccm_addr_lo = dccm_wren ? dccm_wr_addr_lo : dccm_rd_addr_lo;
   assign dccm_addr_hi = dccm_wren ? dccm_wr_addr_hi : dccm_rd_addr_hi;
   assign dccm_bank_lo = dccm_addr_lo[3:2];
   assign dccm_bank_hi = dccm_addr_hi[3:2];
   assign dccm_access  = dccm_wren | dccm_rden;
   assign dccm_rd_go   = dccm_rden & ~dccm_wren;

   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++) begin
         // Hi side only when it lands in another bank
         dccm_bank_sel_hi[i] = (dccm_bank_hi == bank_idx_t'(i)) && (dccm_bank_hi != dccm_bank_lo);
         dccm_bank_en[i]     = dccm_access &
                               ((dccm_bank_lo == bank_idx_t'(i)) | dccm_bank_sel_hi[i]);
         dccm_bank_we[i]     = dccm_wren & dccm_bank_en[i];
         dccm_bank_row[i]    = dccm_bank_sel_hi[i] ? dccm_addr_hi[DCCM_BITS-1:4]
                                                   : dccm_addr_lo[DCCM_BITS-1:4];
      end
   end

   // ******************************
   // ICCM decode
   // ******************************
   assign iccm_addr_nxt = iccm_rw_addr + 1'b1;   // Bank 3 wraps into the next row
   assign iccm_bank_0   = iccm_rw_addr[1:0];
   assign iccm_bank_1   = iccm_addr_nxt[1:0];
   assign iccm_access   = iccm_wren | iccm_rden;
   assign iccm_second   = iccm_wren ? (iccm_wr_size == 3'b011) : iccm_rden;
   assign iccm_rd_go    = iccm_rden & ~iccm_wren;

   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++) begin
         iccm_bank_sel_hi[i] = iccm_second & (iccm_bank_1 == bank_idx_t'(i));
         iccm_bank_en[i]     = iccm_access &
                               ((iccm_bank_0 == bank_idx_t'(i)) | iccm_bank_sel_hi[i]);
         iccm_bank_we[i]     = iccm_wren & iccm_bank_en[i];
         iccm_bank_row[i]    = iccm_bank_sel_hi[i] ? iccm_addr_nxt[ICCM_BITS-3:2]
                                                   : iccm_rw_addr[ICCM_BITS-3:2];
      end
   end

   // Bank numbers for the output muxes one cycle later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dccm_rd_bank_lo_q <= '0;
         dccm_rd_bank_hi_q <= '0;
         iccm_rd_bank_q    <= '0;
      end else begin
         if (dccm_rd_go) begin
            dccm_rd_bank_lo_q <= dccm_bank_lo;
            dccm_rd_bank_hi_q <= dccm_bank_hi;   // Same bank gives the lo word twice
         end
         if (iccm_rd_go) begin
            iccm_rd_bank_q <= iccm_bank_0;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/dccm_mem.sv
// ECC bits are stored and returned as given, nothing is checked here
`timescale 1ns/1ps
`default_nettype none

module dccm_mem import ccm_pkg::*; (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire bank_vec_t       dccm_bank_en,
   input  wire bank_vec_t       dccm_bank_we,
   input  wire bank_vec_t       dccm_bank_sel_hi,
   input  wire row_t [NUM_BANKS-1:0] dccm_bank_row,
   input  wire bank_idx_t       dccm_rd_bank_lo_q,
   input  wire bank_idx_t       dccm_rd_bank_hi_q,
   input  wire fdata_t          dccm_wr_data_lo,
   input  wire fdata_t          dccm_wr_data_hi,
   output fdata_t               dccm_rd_data_lo,
   output fdata_t               dccm_rd_data_hi
);

   fdata_t bank_wdata [NUM_BANKS];
   fdata_t bank_rdata [NUM_BANKS];

   // ******************************
   // Banks
   // ******************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign bank_wdata[i] = dccm_bank_sel_hi[i] ? dccm_wr_data_hi : dccm_wr_data_lo;

      sram_bank u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .en    (dccm_bank_en[i]),
         .we    (dccm_bank_we[i]),
         .row   (dccm_bank_row[i]),
         .wdata (bank_wdata[i]),
         .rdata (bank_rdata[i])
      );
   end

   // Reorder by the registered bank numbers
   assign dccm_rd_data_lo = bank_rdata[dccm_rd_bank_lo_q];
   assign dccm_rd_data_hi = bank_rdata[dccm_rd_bank_hi_q];

endmodule

`default_nettype wire

// File: hdl/iccm_mem.sv
// Write data arrives already encoded; fetches are word aligned and always 64 bits
`timescale 1ns/1ps
`default_nettype none

module iccm_mem import ccm_pkg::*; (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       ecc_disable,
   input  wire bank_vec_t            iccm_bank_en,
   input  wire bank_vec_t            iccm_bank_we,
   input  wire bank_vec_t            iccm_bank_sel_hi,
   input  wire row_t [NUM_BANKS-1:0] iccm_bank_row,
   input  wire bank_idx_t            iccm_rd_bank_q,
   input  wire [2*FDATA_WIDTH-1:0]   iccm_wr_data,
   output logic [2*DATA_WIDTH-1:0]   iccm_rd_data,
   output logic [2*FDATA_WIDTH-1:0]  iccm_rd_data_ecc,
   output logic [1:0]                iccm_sb_err,
   output logic [1:0]                iccm_db_err
);

   fdata_t    bank_wdata [NUM_BANKS];
   fdata_t    bank_rdata [NUM_BANKS];
   bank_idx_t bank_nxt_q;
   fdata_t    rd_lo;
   fdata_t    rd_hi;
   data_t     dec_lo;
   data_t     dec_hi;
   logic      sb_lo;
   logic      sb_hi;
   logic      db_lo;
   logic      db_hi;

   // ******************************
   // Banks
   // ******************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign bank_wdata[i] = iccm_bank_sel_hi[i] ? iccm_wr_data[2*FDATA_WIDTH-1:FDATA_WIDTH]
                                                 : iccm_wr_data[FDATA_WIDTH-1:0];

      sram_bank u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .en    (iccm_bank_en[i]),
         .we    (iccm_bank_we[i]),
         .row   (iccm_bank_row[i]),
         .wdata (bank_wdata[i]),
         .rdata (bank_rdata[i])
      );
   end

   // Fetch pair, next word from the following bank
   assign bank_nxt_q       = iccm_rd_bank_q + 1'b1;
   assign rd_lo            = bank_rdata[iccm_rd_bank_q];
   assign rd_hi            = bank_rdata[bank_nxt_q];
   assign iccm_rd_data_ecc = {rd_hi, rd_lo};

   // ******************************
   // ECC check per half
   // ******************************
   secded_decode u_dec_lo (
      .codeword (rd_lo),
      .data     (dec_lo),
      .sb_err   (sb_lo),
      .db_err   (db_lo)
   );

   secded_decode u_dec_hi (
      .codeword (rd_hi),
      .data     (dec_hi),
      .sb_err   (sb_hi),
      .db_err   (db_hi)
   );

   assign iccm_rd_data = ecc_disable ? {rd_hi[DATA_WIDTH-1:0], rd_lo[DATA_WIDTH-1:0]}
                                     : {dec_hi, dec_lo};
   assign iccm_sb_err  = {sb_hi, sb_lo} & {2{~ecc_disable}};
   assign iccm_db_err  = {db_hi, db_lo} & {2{~ecc_disable}};

endmodule

`default_nettype wire

// File: hdl/ccm_mem_top.sv
// Read data is valid the cycle after a read strobe and held until the next one; no back-pressure
`timescale 1ns/1ps
`default_nettype none

module ccm_mem_top (
   input  wire         clk,
   input  wire         rst_n,
   input  wire         ecc_disable,

   // DCCM
   input  wire         dccm_wren,
   input  wire         dccm_rden,
   input  wire [11:0]  dccm_wr_addr_lo,
   input  wire [11:0]  dccm_wr_addr_hi,
   input  wire [11:0]  dccm_rd_addr_lo,
   input  wire [11:0]  dccm_rd_addr_hi,
   input  wire [38:0]  dccm_wr_data_lo,
   input  wire [38:0]  dccm_wr_data_hi,
   output logic [38:0] dccm_rd_data_lo,
   output logic [38:0] dccm_rd_data_hi,

   // ICCM
   input  wire         iccm_wren,
   input  wire         iccm_rden,
   input  wire [9:0]   iccm_rw_addr,     // Word address
   input  wire [2:0]   iccm_wr_size,
   input  wire [77:0]  iccm_wr_data,
   output logic [63:0] iccm_rd_data,
   output logic [77:0] iccm_rd_data_ecc,
   output logic [1:0]  iccm_sb_err,
   output logic [1:0]  iccm_db_err
);

   // ******************************
   // Bank controls
   // ******************************
   logic [3:0]      dccm_bank_en;
   logic [3:0]      dccm_bank_we;
   logic [3:0]      dccm_bank_sel_hi;
   logic [3:0][7:0] dccm_bank_row;
   logic [1:0]      dccm_rd_bank_lo_q;
   logic [1:0]      dccm_rd_bank_hi_q;

   logic [3:0]      iccm_bank_en;
   logic [3:0]      iccm_bank_we;
   logic [3:0]      iccm_bank_sel_hi;
   logic [3:0][7:0] iccm_bank_row;
   logic [1:0]      iccm_rd_bank_q;

   ccm_ctrl u_ctrl (.*);

   dccm_mem u_dccm (.*);

   iccm_mem u_iccm (.*);

endmodule

`default_nettype wire

// File: include/ccm_tb_ecc.svh
// Reference models for the testbench; shadow words start unknown, so only read back written words
`ifndef CCM_TB_ECC_SVH
`define CCM_TB_ECC_SVH

fdata_t dccm_shadow [1024];   // Indexed by byte address bits 11:2
fdata_t iccm_shadow [1024];   // Indexed by word address

// Hamming check bits over positions 1..38, overall parity on top
function automatic fdata_t ecc_encode(input data_t d);
   logic [6:0] ecc;
   int         pos;
   ecc = '0;
   pos = 1;
   for (int i = 0; i < 32; i++) begin
      pos++;
      while ((pos & (pos - 1)) == 0) pos++;   // Skip check bit slots
      for (int k = 0; k < 6; k++) begin
         if (pos[k]) ecc[k] = ecc[k] ^ d[i];
      end
   end
   ecc[6] = ^{ecc[5:0], d};
   return {ecc, d};
endfunction

// Hi word lands only in a bank other than the lo bank
function automatic void dccm_model_write(input dccm_addr_t lo, input dccm_addr_t hi,
                                         input fdata_t dlo, input fdata_t dhi);
   dccm_shadow[lo[11:2]] = dlo;
   if (hi[3:2] != lo[3:2]) dccm_shadow[hi[11:2]] = dhi;
endfunction

function automatic void iccm_model_write(input iccm_addr_t a, input logic [2:0] size,
                                         input logic [77:0] d);
   iccm_addr_t nxt;
   nxt = a + 1'b1;
   iccm_shadow[a] = d[38:0];
   if (size == 3'b011) iccm_shadow[nxt] = d[77:39];
endfunction

`endif

// File: verification/ccm_tb.sv
// Self-checking testbench for ccm_mem_top; built for Verilator with --timing and --assert
`timescale 1ns/1ps
`default_nettype none

module ccm_tb import ccm_pkg::*;;

   localparam int PLANNED_CYCLES = 2000;
   localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        ecc_disable;
   logic        dccm_wren, dccm_rden;
   logic [11:0] dccm_wr_addr_lo, dccm_wr_addr_hi, dccm_rd_addr_lo, dccm_rd_addr_hi;
   logic [38:0] dccm_wr_data_lo, dccm_wr_data_hi;
   wire  [38:0] dccm_rd_data_lo, dccm_rd_data_hi;
   logic        iccm_wren, iccm_rden;
   logic [9:0]  iccm_rw_addr;
   logic [2:0]  iccm_wr_size;
   logic [77:0] iccm_wr_data;
   wire  [63:0] iccm_rd_data;
   wire  [77:0] iccm_rd_data_ecc;
   wire  [1:0]  iccm_sb_err, iccm_db_err;

   logic [15:0] lfsr = 16'd64;
   int          cycle_count = 0;

   `include "ccm_tb_ecc.svh"

   ccm_mem_top u_dut (.*);

   always #5 clk = ~clk;

   // Watchdog
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   // Taps 16 14 13 11 and one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [77:0] got,
                              input logic [77:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   // ******************************
   // Bus tasks entered at a falling edge
   // ******************************
   task automatic dccm_write(input dccm_addr_t lo, input dccm_addr_t hi,
                             input fdata_t dlo, input fdata_t dhi);
      dccm_wren = 1'b1;
      dccm_wr_addr_lo = lo;
      dccm_wr_addr_hi = hi;
      dccm_wr_data_lo = dlo;
      dccm_wr_data_hi = dhi;
      dccm_model_write(lo, hi, dlo, dhi);
      @(negedge clk);
      dccm_wren = 1'b0;
   endtask

   task automatic dccm_read(input dccm_addr_t lo, input dccm_addr_t hi,
                            output fdata_t exp_lo, output fdata_t exp_hi);
      exp_lo = dccm_shadow[lo[11:2]];
      exp_hi = (hi[3:2] == lo[3:2]) ? exp_lo : dccm_shadow[hi[11:2]];  // Same bank
      dccm_rden = 1'b1;
      dccm_rd_addr_lo = lo;
      dccm_rd_addr_hi = hi;
      @(negedge clk);
      dccm_rden = 1'b0;
      check_value("dccm_rd_data_lo", 78'(dccm_rd_data_lo), 78'(exp_lo));
      check_value("dccm_rd_data_hi", 78'(dccm_rd_data_hi), 78'(exp_hi));
   endtask

   task automatic iccm_write(input iccm_addr_t a, input logic [2:0] size,
                             input logic [77:0] d);
      iccm_wren = 1'b1;
      iccm_rw_addr = a;
      iccm_wr_size = size;
      iccm_wr_data = d;
      iccm_model_write(a, size, d);
      @(negedge clk);
      iccm_wren = 1'b0;
   endtask

   // Data check skipped for double errors
   task automatic iccm_fetch(input iccm_addr_t a, input logic [63:0] exp_data,
                             input logic chk_data, input logic [1:0] exp_sb,
                             input logic [1:0] exp_db);
      iccm_addr_t nxt;
      nxt = a + 1'b1;
      iccm_rden = 1'b1;
      iccm_rw_addr = a;
      @(negedge clk);
      iccm_rden = 1'b0;
      check_value("iccm_rd_data_ecc", iccm_rd_data_ecc,
                  {iccm_shadow[nxt], iccm_shadow[a]});
      if (chk_data) check_value("iccm_rd_data", 78'(iccm_rd_data), 78'(exp_data));
      check_value("iccm_sb_err", 78'(iccm_sb_err), 78'(exp_sb));
      check_value("iccm_db_err", 78'(iccm_db_err), 78'(exp_db));
   endtask

   initial begin
      dccm_addr_t lo, hi;
      fdata_t     w0, w1, exp_lo, exp_hi;
      iccm_addr_t a;
      data_t      d0, d1;
      fdata_t     cw [2];
      int         h, b, b2;
      {rst_n, ecc_disable, dccm_wren, dccm_rden, iccm_wren, iccm_rden} = '0;
      {dccm_wr_addr_lo, dccm_wr_addr_hi, dccm_rd_addr_lo, dccm_rd_addr_hi} = '0;
      {dccm_wr_data_lo, dccm_wr_data_hi, iccm_rw_addr, iccm_wr_data} = '0;
      iccm_wr_size = 3'b010;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Reset values
      check_value("dccm_rd_data_lo", 78'(dccm_rd_data_lo), '0);
      check_value("dccm_rd_data_hi", 78'(dccm_rd_data_hi), '0);
      check_value("iccm_rd_data", 78'(iccm_rd_data), '0);
      check_value("iccm_rd_data_ecc", iccm_rd_data_ecc, '0);
      check_value("iccm_sb_err", 78'(iccm_sb_err), '0);
      check_value("iccm_db_err", 78'(iccm_db_err), '0);

      // ******************************
      // DCCM lo/hi pairs
      // ******************************
      for (int i = 0; i < 40; i++) begin
         lo = dccm_addr_t'(rand_bits(12));
         hi = (i % 5 == 0) ? {8'(rand_bits(8)), lo[3:2], 2'b00}   // Force same bank
                           : dccm_addr_t'(rand_bits(12));
         w0 = {7'(rand_bits(7)), rand_bits(32)};
         w1 = {7'(rand_bits(7)), rand_bits(32)};
         dccm_write(lo, hi, w0, w1);
         dccm_read(lo, hi, exp_lo, exp_hi);
         repeat (2) @(negedge clk);   // Held over idle and a write
         dccm_write(dccm_addr_t'(rand_bits(12)), dccm_addr_t'(rand_bits(12)), ~w0, ~w1);
         check_value("dccm_rd_data_lo", 78'(dccm_rd_data_lo), 78'(exp_lo));
         check_value("dccm_rd_data_hi", 78'(dccm_rd_data_hi), 78'(exp_hi));
      end

      // ******************************
      // ICCM clean fetches
      // ******************************
      for (int i = 0; i < 40; i++) begin
         a = iccm_addr_t'(rand_bits(10));
         if (i % 4 == 0) a[1:0] = 2'b11;   // Wrap into the next row
         d0 = rand_bits(32);
         d1 = rand_bits(32);
         if (rand_bits(1) == 1) begin
            iccm_write(a, 3'b011, {ecc_encode(d1), ecc_encode(d0)});
         end else begin
            iccm_write(a, 3'b010, {39'h0, ecc_encode(d0)});
            iccm_write(a + 1'b1, 3'b010, {39'h0, ecc_encode(d1)});
         end
         iccm_fetch(a, {d1, d0}, 1'b1, 2'b00, 2'b00);
         iccm_write(a + 2'd2, 3'b010, '0);
         check_value("iccm_rd_data", 78'(iccm_rd_data), 78'({d1, d0}));
      end

      // ******************************
      // ICCM single and double errors
      // ******************************
      for (int i = 0; i < 12; i++) begin
         a = iccm_addr_t'(rand_bits(10));
         d0 = rand_bits(32);
         d1 = rand_bits(32);
         h = rand_bits(1);
         b = rand_bits(6) % 39;
         b2 = (b + 1 + rand_bits(6) % 38) % 39;
         cw[0] = ecc_encode(d0);
         cw[1] = ecc_encode(d1);
         cw[h][b] = ~cw[h][b];
         ecc_disable = 1'b0;
         iccm_write(a, 3'b011, {cw[1], cw[0]});
         iccm_fetch(a, {d1, d0}, 1'b1, 2'(1 << h), 2'b00);
         ecc_disable = 1'b1;
         iccm_fetch(a, {cw[1][31:0], cw[0][31:0]}, 1'b1, 2'b00, 2'b00);
         cw[h][b2] = ~cw[h][b2];
         ecc_disable = 1'b0;
         iccm_write(a, 3'b011, {cw[1], cw[0]});
         iccm_fetch(a, '0, 1'b0, 2'b00, 2'(1 << h));
         ecc_disable = 1'b1;
         iccm_fetch(a, {cw[1][31:0], cw[0][31:0]}, 1'b1, 2'b00, 2'b00);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hdl/ccm_pkg.sv
hdl/sram_bank.sv
hdl/secded_decode.sv
hdl/ccm_ctrl.sv
hdl/dccm_mem.sv
hdl/iccm_mem.sv
hdl/ccm_mem_top.sv
verification/ccm_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; exit status is the simulator's
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module ccm_tb -o ccm_sim &&
./obj_dir/ccm_sim || exit 1
